// ==== Makefile ====
SIM = obj_dir/Vtb_echo_delay

.PHONY: all run clean

all: $(SIM)

$(SIM): $(wildcard *.sv *.svh) build.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_echo_delay -f build.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== apb_ctrl_decode.sv ====
`include "echo_settings.svh"

module apb_ctrl_decode
    import echo_types_pkg::*;
    import apb_map_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_psel,
    input  logic       i_penable,
    input  logic       i_pwrite,
    input  logic [7:0] i_paddr,
    input  apb_data_t  i_pwdata,
    output apb_data_t  o_prdata,
    output logic       o_pready,
    output logic       o_pslverr,
    ctrl_if.decoder    ctrl,
    tap_if.sink        taps,
    input  acc_t       i_acc
);
    logic       access;
    logic       delta_ok;
    logic       ctrl_wr;
    logic       delta_wr;
    logic [3:0] cmd_d;
    logic [3:0] cmd_q;
    delta_t     delta_q;

    assign access   = i_psel && i_penable;
    assign delta_ok = (i_pwdata >= `DELTA_START) && (i_pwdata <= `DELTA_LAST);
    assign ctrl_wr  = access && i_pwrite && (i_paddr == REG_CTRL);
    assign delta_wr = access && i_pwrite && (i_paddr == REG_DELTA) && delta_ok;
    assign o_pready = 1'b1;

    always_comb begin
        o_pslverr = 1'b0;
        o_prdata  = '0;
        if (access) begin
            case (i_paddr)
                REG_CTRL: begin
                    o_pslverr = !i_pwrite;
                end
                REG_DELTA: begin
                    if (i_pwrite) begin
                        o_pslverr = !delta_ok;
                    end else begin
                        o_prdata = apb_data_t'(delta_q);
                    end
                end
                REG_STATUS: begin
                    o_pslverr = i_pwrite;
                    o_prdata  = apb_data_t'(ctrl.state);
                end
                REG_TAPS: begin
                    o_pslverr = i_pwrite;
                    o_prdata  = {taps.far, taps.near};
                end
                REG_CORR_LO: begin
                    o_pslverr = i_pwrite;
                    o_prdata  = i_acc[31:0];
                end
                REG_CORR_HI: begin
                    o_pslverr = i_pwrite;
                    o_prdata  = {{(64 - `ACC_WIDTH){i_acc[`ACC_WIDTH-1]}}, i_acc[`ACC_WIDTH-1:32]};
                end
                default: begin
                    o_pslverr = 1'b1;
                end
            endcase
        end
    end

    // each command bit of a ctrl write becomes a one-cycle pulse.
    assign cmd_d = ctrl_wr ? i_pwdata[3:0] : 4'b0000;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            cmd_q   <= '0;
            delta_q <= delta_t'(`DELTA_START);
        end else begin
            cmd_q <= cmd_d;
            if (delta_wr) begin
                delta_q <= delta_t'(i_pwdata);
            end
        end
    end

    assign ctrl.start   = cmd_q[CTRL_START];
    assign ctrl.iterate = cmd_q[CTRL_ITERATE];
    assign ctrl.clear   = cmd_q[CTRL_CLEAR];
    assign ctrl.stop    = cmd_q[CTRL_STOP];
    assign ctrl.delta   = delta_q;

    assert property (@(posedge i_clk) disable iff (i_rst) i_penable |-> i_psel);

    assert property (@(posedge i_clk) disable iff (i_rst) $onehot0(cmd_q));

endmodule

// ==== apb_map_pkg.sv ====
package apb_map_pkg;

    // register byte offsets.
    typedef enum logic [7:0] {
        REG_CTRL    = 8'h00,
        REG_DELTA   = 8'h04,
        REG_STATUS  = 8'h08,
        REG_TAPS    = 8'h0C,
        REG_CORR_LO = 8'h10,
        REG_CORR_HI = 8'h14
    } reg_addr_e;

    // command bits in REG_CTRL.
    localparam int unsigned CTRL_START   = 0;
    localparam int unsigned CTRL_ITERATE = 1;
    localparam int unsigned CTRL_CLEAR   = 2;
    localparam int unsigned CTRL_STOP    = 3;

    typedef logic [31:0] apb_data_t;

endpackage

// ==== build.f ====
+incdir+.
echo_types_pkg.sv
apb_map_pkg.sv
echo_ifs.sv
i2s_recorder.sv
apb_ctrl_decode.sv
ring_buffer.sv
tap_correlator.sv
echo_delay_top.sv
tb_clock_gen.sv
tb_echo_delay.sv

// ==== echo_delay_top.sv ====
module echo_delay_top
    import echo_types_pkg::*;
    import apb_map_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_bclk,
    input  logic       i_lrck,
    input  logic       i_data,
    input  logic       i_psel,
    input  logic       i_penable,
    input  logic       i_pwrite,
    input  logic [7:0] i_paddr,
    input  apb_data_t  i_pwdata,
    output apb_data_t  o_prdata,
    output logic       o_pready,
    output logic       o_pslverr
);
    sample_t sample;
    logic    sample_valid;
    acc_t    acc;

    ctrl_if ctrl ();
    tap_if  taps ();

    i2s_recorder u_recorder (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_bclk         (i_bclk),
        .i_lrck         (i_lrck),
        .i_data         (i_data),
        .o_sample       (sample),
        .o_sample_valid (sample_valid)
    );

    apb_ctrl_decode u_decode (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .ctrl      (ctrl.decoder),
        .taps      (taps.sink),
        .i_acc     (acc)
    );

    ring_buffer u_buffer (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_sample       (sample),
        .i_sample_valid (sample_valid),
        .ctrl           (ctrl.buffer),
        .taps           (taps.source)
    );

    tap_correlator u_correlator (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .taps  (taps.sink),
        .ctrl  (ctrl.monitor),
        .o_acc (acc)
    );

endmodule

// ==== echo_ifs.sv ====
interface ctrl_if
    import echo_types_pkg::*;
();
    logic       start;
    logic       iterate;
    logic       clear;
    logic       stop;
    delta_t     delta;
    buf_state_e state;

    modport decoder (
        output start,
        output iterate,
        output clear,
        output stop,
        output delta,
        input  state
    );

    modport buffer (
        input  start,
        input  iterate,
        input  stop,
        input  delta,
        output state
    );

    // correlator only needs the clear pulse and the phase.
    modport monitor (
        input clear,
        input state
    );
endinterface

interface tap_if
    import echo_types_pkg::*;
();
    sample_t near;
    sample_t far;
    logic    tap_valid;

    modport source (output near, output far, output tap_valid);
    modport sink (input near, input far, input tap_valid);
endinterface

// ==== echo_settings.svh ====
`ifndef ECHO_SETTINGS_SVH
`define ECHO_SETTINGS_SVH

// width of one signed audio sample.
`define READBIT 16

// number of entries in the ring buffer.
`define BUFFER_LENGTH 16

// legal delay window, in samples.
`define DELTA_START 4
`define DELTA_LAST 11

// distance between near and far taps.
`define L 4

// correlator accumulator width, wraps on overflow.
`define ACC_WIDTH 40

`endif

// ==== echo_types_pkg.sv ====
`include "echo_settings.svh"

package echo_types_pkg;

    // buffer phase.
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_INITIAL = 2'd1,
        ST_ITERATE = 2'd2
    } buf_state_e;

    typedef logic signed [`READBIT-1:0] sample_t;

    typedef logic [$clog2(`BUFFER_LENGTH)-1:0] ptr_t;

    // holds any value up to DELTA_LAST.
    typedef logic [$clog2(`DELTA_LAST+1)-1:0] delta_t;

    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

endpackage

// ==== i2s_recorder.sv ====
`include "echo_settings.svh"

module i2s_recorder
    import echo_types_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_bclk,
    input  logic    i_lrck,
    input  logic    i_data,
    output sample_t o_sample,
    output logic    o_sample_valid
);
    typedef logic [$clog2(`READBIT)-1:0] bit_cnt_t;

    logic [1:0] bclk_sync;
    logic [1:0] lrck_sync;
    logic [1:0] data_sync;
    logic       bclk_prev;
    logic       bclk_rise;
    logic       lrck_prev;
    logic       capturing;
    bit_cnt_t   bit_cnt;
    sample_t    shift_q;
    logic       valid_q;

    assign bclk_rise = bclk_sync[1] && !bclk_prev;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            bclk_sync <= '0;
            lrck_sync <= '0;
            data_sync <= '0;
            bclk_prev <= 1'b0;
            lrck_prev <= 1'b0;
            capturing <= 1'b0;
            bit_cnt   <= '0;
            valid_q   <= 1'b0;
        end else begin
            bclk_sync <= {bclk_sync[0], i_bclk};
            lrck_sync <= {lrck_sync[0], i_lrck};
            data_sync <= {data_sync[0], i_data};
            bclk_prev <= bclk_sync[1];
            valid_q   <= bclk_rise && capturing && (bit_cnt == bit_cnt_t'(`READBIT - 1));
            if (bclk_rise) begin
                lrck_prev <= lrck_sync[1];
                // first bclk after lrck falls is the i2s one-bit delay.
                if (lrck_prev && !lrck_sync[1]) begin
                    capturing <= 1'b1;
                    bit_cnt   <= '0;
                end else if (capturing) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == bit_cnt_t'(`READBIT - 1)) begin
                        capturing <= 1'b0;
                    end
                end
            end
        end
    end

    // msb first.
    always_ff @(posedge i_clk) begin
        if (bclk_rise && capturing) begin
            shift_q <= {shift_q[`READBIT-2:0], data_sync[1]};
        end
    end

    assign o_sample       = shift_q;
    assign o_sample_valid = valid_q;

endmodule

// ==== ring_buffer.sv ====
`include "echo_settings.svh"

module ring_buffer
    import echo_types_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  sample_t i_sample,
    input  logic    i_sample_valid,
    ctrl_if.buffer  ctrl,
    tap_if.source   taps
);
    buf_state_e state_q;
    buf_state_e state_d;
    sample_t    mem [`BUFFER_LENGTH];
    ptr_t       ptr_q;
    ptr_t       near_idx;
    ptr_t       far_idx;
    sample_t    near_q;
    sample_t    far_q;
    logic       wr_en;
    logic       wr_seen_q;
    logic       tap_valid_q;

    // entry at base + dly - DELTA_START - back, modulo the buffer length.
    function automatic ptr_t tap_index(input ptr_t base, input delta_t dly, input int back);
        int sum;
        sum = int'(base) + int'(dly) - `DELTA_START - back + `BUFFER_LENGTH;
        return ptr_t'(sum % `BUFFER_LENGTH);
    endfunction

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (ctrl.start) begin
                    state_d = ST_INITIAL;
                end
            end
            ST_INITIAL: begin
                if (ctrl.stop) begin
                    state_d = ST_IDLE;
                end else if (ctrl.iterate) begin
                    state_d = ST_ITERATE;
                end
            end
            ST_ITERATE: begin
                if (ctrl.stop) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    assign wr_en    = i_sample_valid && (state_q != ST_IDLE);
    assign near_idx = tap_index(ptr_q, ctrl.delta, 0);
    assign far_idx  = tap_index(ptr_q, ctrl.delta, `L);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q     <= ST_IDLE;
            ptr_q       <= '0;
            near_q      <= '0;
            far_q       <= '0;
            wr_seen_q   <= 1'b0;
            tap_valid_q <= 1'b0;
            for (int i = 0; i < `BUFFER_LENGTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            state_q   <= state_d;
            wr_seen_q <= wr_en;
            // taps catch up one cycle after the write.
            tap_valid_q <= wr_seen_q && (state_d != ST_IDLE);
            if (state_q == ST_IDLE) begin
                ptr_q <= '0;
                for (int i = 0; i < `BUFFER_LENGTH; i++) begin
                    mem[i] <= '0;
                end
            end else if (wr_en) begin
                mem[ptr_q] <= i_sample;
                ptr_q      <= (ptr_q == ptr_t'(`BUFFER_LENGTH - 1)) ? '0 : ptr_q + 1'b1;
            end
            case (state_q)
                ST_INITIAL: begin
                    near_q <= mem[near_idx];
                end
                ST_ITERATE: begin
                    near_q <= mem[near_idx];
                    far_q  <= mem[far_idx];
                end
                default: begin
                    near_q <= '0;
                    far_q  <= '0;
                end
            endcase
        end
    end

    assign ctrl.state     = state_q;
    assign taps.near      = near_q;
    assign taps.far       = far_q;
    assign taps.tap_valid = tap_valid_q;

    assert property (@(posedge i_clk) disable iff (i_rst)
        (state_q != ST_IDLE) |-> (ctrl.delta >= `DELTA_START && ctrl.delta <= `DELTA_LAST));

endmodule

// ==== tap_correlator.sv ====
`include "echo_settings.svh"

module tap_correlator
    import echo_types_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    tap_if.sink     taps,
    ctrl_if.monitor ctrl,
    output acc_t    o_acc
);
    logic signed [2*`READBIT-1:0] product;
    acc_t                         acc_q;

    // full-width signed product of the two taps.
    assign product = taps.near * taps.far;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            acc_q <= '0;
        end else if (ctrl.clear || ctrl.state == ST_IDLE) begin
            // idle keeps the sum at zero, so a stop also clears it.
            acc_q <= '0;
        end else if (taps.tap_valid && ctrl.state == ST_ITERATE) begin
            acc_q <= acc_q + acc_t'(product);
        end
    end

    assign o_acc = acc_q;

    assert property (@(posedge i_clk) disable iff (i_rst)
        (ctrl.state == ST_IDLE) |-> !taps.tap_valid);

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic o_clk
);
    // half period of 5 gives a period of 10.
    initial begin
        o_clk = 1'b0;
        forever begin
            #5 o_clk = ~o_clk;
        end
    end

endmodule

// ==== tb_echo_delay.sv ====
`include "echo_settings.svh"

module tb_echo_delay
    import echo_types_pkg::*;
    import apb_map_pkg::*;
();
    localparam int TIMEOUT = 2000;

    logic       clk;
    logic       rst;
    logic       bclk;
    logic       lrck;
    logic       sdata;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;

    logic [15:0] lfsr;
    int          frames_sent;
    int          samples_seen = 0;

    // reference model of the buffer and the correlator.
    sample_t    model_mem [`BUFFER_LENGTH];
    int         model_ptr;
    int         model_delta;
    buf_state_e model_state;
    acc_t       model_sum;

    tb_clock_gen u_clock (.o_clk(clk));

    echo_delay_top uut (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_bclk    (bclk),
        .i_lrck    (lrck),
        .i_data    (sdata),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    // counts recorder words so a frame can be waited on.
    always @(posedge clk) begin
        if (uut.sample_valid) begin
            samples_seen <= samples_seen + 1;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic random_bit();
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return lfsr[0];
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], random_bit()};
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
        assert (got === exp) else
            report_error($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        // no wait states, the access phase is always the second cycle.
        check_value("PREADY", apb_data_t'(pready), 32'd1);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input apb_data_t data, input logic exp_err);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value("PSLVERR", apb_data_t'(err), apb_data_t'(exp_err));
    endtask

    task automatic check_read(input string name, input logic [7:0] addr, input logic exp_err,
                              input apb_data_t exp);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        check_value("PSLVERR", apb_data_t'(err), apb_data_t'(exp_err));
        if (!exp_err) begin
            check_value(name, rdata, exp);
        end
    endtask

    task automatic set_delta(input int d);
        reg_write(REG_DELTA, apb_data_t'(d), 1'b0);
        model_delta = d;
    endtask

    // entry that lies back entries behind the near tap.
    function automatic int model_index(input int back);
        return (model_ptr + model_delta - `DELTA_START - back + 2 * `BUFFER_LENGTH)
            % `BUFFER_LENGTH;
    endfunction

    function automatic apb_data_t expected_taps();
        sample_t near_v;
        sample_t far_v;
        near_v = '0;
        far_v  = '0;
        if (model_state != ST_IDLE) begin
            near_v = model_mem[model_index(0)];
        end
        // far tap only moves in iterate and is still zero from idle in initial.
        if (model_state == ST_ITERATE) begin
            far_v = model_mem[model_index(`L)];
        end
        return {far_v, near_v};
    endfunction

    task automatic model_sample(input sample_t s);
        logic signed [2*`READBIT-1:0] prod;
        if (model_state != ST_IDLE) begin
            model_mem[model_ptr] = s;
            model_ptr = (model_ptr + 1) % `BUFFER_LENGTH;
            if (model_state == ST_ITERATE) begin
                prod = model_mem[model_index(0)] * model_mem[model_index(`L)];
                model_sum = model_sum + prod;
            end
        end
    endtask

    task automatic model_clear();
        for (int i = 0; i < `BUFFER_LENGTH; i++) begin
            model_mem[i] = '0;
        end
        model_ptr   = 0;
        model_sum   = '0;
        model_state = ST_IDLE;
    endtask

    // one bclk period, inputs change while bclk is low.
    task automatic i2s_slot(input logic lr, input logic d);
        @(negedge clk);
        bclk  = 1'b0;
        lrck  = lr;
        sdata = d;
        repeat (4) @(negedge clk);
        bclk = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    task automatic send_sample(input sample_t s);
        int waited;
        i2s_slot(1'b0, random_bit());
        for (int i = `READBIT - 1; i >= 0; i--) begin
            i2s_slot(1'b0, s[i]);
        end
        for (int i = `READBIT + 1; i < 32; i++) begin
            i2s_slot(1'b0, random_bit());
        end
        for (int i = 0; i < 32; i++) begin
            i2s_slot(1'b1, random_bit());
        end
        frames_sent++;
        waited = 0;
        while (samples_seen < frames_sent && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (samples_seen == frames_sent) else
            report_error("recorder sample-valid pulses do not match the I2S frames sent");
        repeat (8) @(negedge clk);
        model_sample(s);
    endtask

    task automatic check_corr();
        check_read("CORR_LO", REG_CORR_LO, 1'b0, model_sum[31:0]);
        check_read("CORR_HI", REG_CORR_HI, 1'b0, apb_data_t'(model_sum >>> 32));
    endtask

    initial begin
        logic [7:0] bad_addr;
        rst     = 1'b1;
        bclk    = 1'b0;
        lrck    = 1'b1;
        sdata   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr        = 16'd25;
        frames_sent = 0;
        model_delta = `DELTA_START;
        model_clear();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        // recorder needs to see lrck high before the first frame.
        i2s_slot(1'b1, 1'b0);
        i2s_slot(1'b1, 1'b0);

        check_read("STATUS", REG_STATUS, 1'b0, ST_IDLE);
        check_read("TAPS", REG_TAPS, 1'b0, '0);
        check_corr();
        check_read("DELTA", REG_DELTA, 1'b0, `DELTA_START);

        bad_addr = 8'h18 + 8'(next_bits(5) << 2);
        check_read("unmapped", bad_addr, 1'b1, '0);
        reg_write(bad_addr, next_bits(16), 1'b1);
        reg_write(REG_STATUS, ST_ITERATE, 1'b1);
        check_read("CTRL", REG_CTRL, 1'b1, '0);
        reg_write(REG_DELTA, `DELTA_START - 1, 1'b1);
        reg_write(REG_DELTA, `DELTA_LAST + 1, 1'b1);
        check_read("DELTA", REG_DELTA, 1'b0, `DELTA_START);
        check_read("STATUS", REG_STATUS, 1'b0, ST_IDLE);

        reg_write(REG_CTRL, 1 << CTRL_START, 1'b0);
        model_state = ST_INITIAL;
        check_read("STATUS", REG_STATUS, 1'b0, ST_INITIAL);
        repeat (20) begin
            send_sample(sample_t'(next_bits(`READBIT)));
            set_delta(`DELTA_START + int'(next_bits(3)));
            check_read("TAPS", REG_TAPS, 1'b0, expected_taps());
        end

        reg_write(REG_CTRL, 1 << CTRL_ITERATE, 1'b0);
        model_state = ST_ITERATE;
        check_read("STATUS", REG_STATUS, 1'b0, ST_ITERATE);
        repeat (40) begin
            set_delta(`DELTA_START + int'(next_bits(3)));
            send_sample(sample_t'(next_bits(`READBIT)));
            check_read("TAPS", REG_TAPS, 1'b0, expected_taps());
            check_corr();
        end

        // clear drops the sum only.
        reg_write(REG_CTRL, 1 << CTRL_CLEAR, 1'b0);
        model_sum = '0;
        check_read("TAPS", REG_TAPS, 1'b0, expected_taps());
        check_corr();

        reg_write(REG_CTRL, 1 << CTRL_STOP, 1'b0);
        model_clear();
        check_read("STATUS", REG_STATUS, 1'b0, ST_IDLE);
        send_sample(sample_t'(next_bits(`READBIT)));
        check_read("TAPS", REG_TAPS, 1'b0, '0);
        check_corr();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
